//--- rtl/exePkg.sv
`default_nettype none

package exePkg;

    localparam int DataWidth = 32;

    // Nick 0 is reserved to mean no producer
    localparam int NickWidth = 4;

    typedef enum logic [4:0] {
        OpLui,
        OpAuipc,
        OpJal,
        OpJalr,
        OpBeq,
        OpBne,
        OpBlt,
        OpBge,
        OpBltu,
        OpBgeu,
        OpAddi,
        OpSlti,
        OpSltiu,
        OpXori,
        OpOri,
        OpAndi,
        OpSlli,
        OpSrli,
        OpSrai,
        OpAdd,
        OpSub,
        OpSll,
        OpSlt,
        OpSltu,
        OpXor,
        OpSrl,
        OpSra,
        OpOr,
        OpAnd
    } exeOp;

    // Holds the value once valid, otherwise the nick of the producing operation
    typedef struct packed {
        logic                 valid;
        logic [NickWidth-1:0] nick;
        logic [DataWidth-1:0] value;
    } operandSlot;

    typedef struct packed {
        exeOp                 op;
        logic [DataWidth-1:0] pc;
        logic [DataWidth-1:0] imm;
        logic [NickWidth-1:0] rdNick;
        operandSlot           src1;
        operandSlot           src2;
    } dispatchReq;

    typedef struct packed {
        exeOp                 op;
        logic [DataWidth-1:0] pc;
        logic [DataWidth-1:0] imm;
        logic [NickWidth-1:0] rdNick;
        logic [DataWidth-1:0] rs1Value;
        logic [DataWidth-1:0] rs2Value;
    } issueReq;

    typedef struct packed {
        logic                 valid;
        logic [NickWidth-1:0] nick;
        logic [DataWidth-1:0] data;
        logic                 jumpTaken;
        logic [DataWidth-1:0] jumpTarget;
    } cdbResult;

    typedef struct packed {
        logic run;
        logic flush;
    } ctrlState;

endpackage

`default_nettype wire

//--- rtl/reservationStation.sv
`timescale 1ns/1ps
`default_nettype none

module reservationStation #(
    parameter int RsDepth = 4
) (
    input  logic                clk,
    input  logic                rst,
    input  exePkg::ctrlState    ctrl,
    input  logic                dispatchValid,
    input  exePkg::dispatchReq  dispatch,
    output logic                dispatchReady,
    input  exePkg::cdbResult    cdb,
    input  exePkg::cdbResult    extCdb,
    output logic                issueValid,
    output exePkg::issueReq     issue
);

    localparam int IdxWidth = (RsDepth > 1) ? $clog2(RsDepth) : 1;

    logic [RsDepth-1:0]  busy;
    exePkg::dispatchReq  entries [RsDepth];
    exePkg::dispatchReq  incoming;

    logic                readyFound;
    logic [IdxWidth-1:0] readyIdx;
    logic                freeFound;
    logic [IdxWidth-1:0] freeIdx;
    logic                issueFire;
    logic                dispatchFire;

    // Picks up a broadcast value for a waiting operand and gives the own bus priority
    function automatic exePkg::operandSlot wakeup(
        input exePkg::operandSlot slot,
        input exePkg::cdbResult   busA,
        input exePkg::cdbResult   busB
    );
        exePkg::operandSlot res;
        res = slot;
        if (!slot.valid && slot.nick != '0) begin
            if (busA.valid && busA.nick == slot.nick) begin
                res.valid = 1'b1;
                res.value = busA.data;
            end else if (busB.valid && busB.nick == slot.nick) begin
                res.valid = 1'b1;
                res.value = busB.data;
            end
        end
        return res;
    endfunction

    // A producer broadcasting in the dispatch cycle is caught here
    always_comb begin
        incoming      = dispatch;
        incoming.src1 = wakeup(dispatch.src1, cdb, extCdb);
        incoming.src2 = wakeup(dispatch.src2, cdb, extCdb);
    end

    always_comb begin
        readyFound = 1'b0;
        readyIdx   = '0;
        for (int i = 0; i < RsDepth; i++) begin
            if (!readyFound && busy[i] && entries[i].src1.valid && entries[i].src2.valid) begin
                readyFound = 1'b1;
                readyIdx   = IdxWidth'(i);
            end
        end
        issueFire = ctrl.run && !ctrl.flush && readyFound;

        // The slot leaving on this edge counts as free so it can be refilled at once
        freeFound = 1'b0;
        freeIdx   = '0;
        for (int i = 0; i < RsDepth; i++) begin
            if (!freeFound && (!busy[i] || (issueFire && readyIdx == IdxWidth'(i)))) begin
                freeFound = 1'b1;
                freeIdx   = IdxWidth'(i);
            end
        end
    end

    assign dispatchReady = ctrl.run && !ctrl.flush && freeFound;
    assign dispatchFire  = dispatchValid && dispatchReady;

    always_ff @(posedge clk) begin
        if (rst || ctrl.flush) begin
            busy <= '0;
        end else begin
            for (int i = 0; i < RsDepth; i++) begin
                if (dispatchFire && freeIdx == IdxWidth'(i)) begin
                    busy[i] <= 1'b1;
                end else if (issueFire && readyIdx == IdxWidth'(i)) begin
                    busy[i] <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < RsDepth; i++) begin
            if (dispatchFire && freeIdx == IdxWidth'(i)) begin
                entries[i] <= incoming;
            end else begin
                entries[i].src1 <= wakeup(entries[i].src1, cdb, extCdb);
                entries[i].src2 <= wakeup(entries[i].src2, cdb, extCdb);
            end
        end
    end

    // While run is low the pending issue is held for execute to take later
    always_ff @(posedge clk) begin
        if (rst) begin
            issueValid <= 1'b0;
        end else if (ctrl.run) begin
            issueValid <= issueFire;
        end
    end

    always_ff @(posedge clk) begin
        if (issueFire) begin
            issue.op       <= entries[readyIdx].op;
            issue.pc       <= entries[readyIdx].pc;
            issue.imm      <= entries[readyIdx].imm;
            issue.rdNick   <= entries[readyIdx].rdNick;
            issue.rs1Value <= entries[readyIdx].src1.value;
            issue.rs2Value <= entries[readyIdx].src2.value;
        end
    end

endmodule

`default_nettype wire

//--- rtl/intExecute.sv
`timescale 1ns/1ps
`default_nettype none

module intExecute (
    input  logic             clk,
    input  logic             rst,
    input  logic             run,
    input  logic             issueValid,
    input  exePkg::issueReq  issue,
    output exePkg::cdbResult cdb
);

    logic [exePkg::DataWidth-1:0] rs1;
    logic [exePkg::DataWidth-1:0] rs2;
    logic [exePkg::DataWidth-1:0] imm;
    logic [exePkg::DataWidth-1:0] pc;
    logic [4:0]                   shamtImm;
    logic [4:0]                   shamtReg;

    logic [exePkg::DataWidth-1:0] aluData;
    logic                         aluTaken;
    logic [exePkg::DataWidth-1:0] aluTarget;
    logic                         isBranch;
    logic                         branchCond;

    logic                         resultValid;
    logic [exePkg::NickWidth-1:0] resultNick;
    logic [exePkg::DataWidth-1:0] resultData;
    logic                         resultTaken;
    logic [exePkg::DataWidth-1:0] resultTarget;

    assign rs1      = issue.rs1Value;
    assign rs2      = issue.rs2Value;
    assign imm      = issue.imm;
    assign pc       = issue.pc;
    assign shamtImm = issue.imm[4:0];
    assign shamtReg = issue.rs2Value[4:0];

    always_comb begin
        aluData    = '0;
        aluTaken   = 1'b0;
        aluTarget  = '0;
        isBranch   = 1'b0;
        branchCond = 1'b0;
        case (issue.op)
            exePkg::OpLui:   aluData = imm;
            exePkg::OpAuipc: aluData = pc + imm;
            exePkg::OpJal: begin
                aluData   = pc + 32'd4;
                aluTaken  = 1'b1;
                aluTarget = pc + imm;
            end
            exePkg::OpJalr: begin
                aluData   = pc + 32'd4;
                aluTaken  = 1'b1;
                aluTarget = (rs1 + imm) & ~32'd1;
            end
            exePkg::OpBeq: begin
                isBranch   = 1'b1;
                branchCond = rs1 == rs2;
            end
            exePkg::OpBne: begin
                isBranch   = 1'b1;
                branchCond = rs1 != rs2;
            end
            exePkg::OpBlt: begin
                isBranch   = 1'b1;
                branchCond = $signed(rs1) < $signed(rs2);
            end
            exePkg::OpBge: begin
                isBranch   = 1'b1;
                branchCond = $signed(rs1) >= $signed(rs2);
            end
            exePkg::OpBltu: begin
                isBranch   = 1'b1;
                branchCond = rs1 < rs2;
            end
            exePkg::OpBgeu: begin
                isBranch   = 1'b1;
                branchCond = rs1 >= rs2;
            end
            exePkg::OpAddi:  aluData = rs1 + imm;
            exePkg::OpSlti:  aluData = {31'd0, $signed(rs1) < $signed(imm)};
            exePkg::OpSltiu: aluData = {31'd0, rs1 < imm};
            exePkg::OpXori:  aluData = rs1 ^ imm;
            exePkg::OpOri:   aluData = rs1 | imm;
            exePkg::OpAndi:  aluData = rs1 & imm;
            exePkg::OpSlli:  aluData = rs1 << shamtImm;
            exePkg::OpSrli:  aluData = rs1 >> shamtImm;
            exePkg::OpSrai:  aluData = $signed(rs1) >>> shamtImm;
            exePkg::OpAdd:   aluData = rs1 + rs2;
            exePkg::OpSub:   aluData = rs1 - rs2;
            exePkg::OpSll:   aluData = rs1 << shamtReg;
            exePkg::OpSlt:   aluData = {31'd0, $signed(rs1) < $signed(rs2)};
            exePkg::OpSltu:  aluData = {31'd0, rs1 < rs2};
            exePkg::OpXor:   aluData = rs1 ^ rs2;
            exePkg::OpSrl:   aluData = rs1 >> shamtReg;
            exePkg::OpSra:   aluData = $signed(rs1) >>> shamtReg;
            exePkg::OpOr:    aluData = rs1 | rs2;
            exePkg::OpAnd:   aluData = rs1 & rs2;
            default:         aluData = '0;
        endcase

        // A branch that falls through still reports its next pc
        if (isBranch) begin
            aluTaken  = branchCond;
            aluTarget = branchCond ? pc + imm : pc + 32'd4;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            resultValid <= 1'b0;
        end else begin
            resultValid <= run && issueValid;
        end
    end

    always_ff @(posedge clk) begin
        if (run && issueValid) begin
            resultNick   <= issue.rdNick;
            resultData   <= aluData;
            resultTaken  <= aluTaken;
            resultTarget <= aluTarget;
        end
    end

    assign cdb = '{
        valid:      resultValid,
        nick:       resultNick,
        data:       resultData,
        jumpTaken:  resultTaken,
        jumpTarget: resultTarget
    };

endmodule

`default_nettype wire

//--- rtl/exeCtrlRegs.sv
`timescale 1ns/1ps
`default_nettype none

module exeCtrlRegs (
    input  logic             clk,
    input  logic             rst,
    input  logic [3:0]       paddr,
    input  logic             psel,
    input  logic             penable,
    input  logic             pwrite,
    input  logic [31:0]      pwdata,
    output logic [31:0]      prdata,
    output logic             pready,
    input  exePkg::cdbResult cdb,
    output exePkg::ctrlState ctrl
);

    localparam logic [3:0] CtrlAddr  = 4'h0;
    localparam logic [3:0] DoneAddr  = 4'h4;
    localparam logic [3:0] TakenAddr = 4'h8;

    logic        apbWrite;
    logic        runReg;
    logic        flushReg;
    logic [31:0] doneCount;
    logic [31:0] takenCount;

    assign apbWrite = psel && penable && pwrite;
    assign pready   = 1'b1;

    always_ff @(posedge clk) begin
        if (rst) begin
            runReg   <= 1'b0;
            flushReg <= 1'b0;
        end else begin
            if (apbWrite && paddr == CtrlAddr) begin
                runReg <= pwdata[0];
            end
            // Flush drops again on the next edge
            flushReg <= apbWrite && paddr == CtrlAddr && pwdata[1];
        end
    end

    always_ff @(posedge clk) begin
        if (rst || (apbWrite && paddr == DoneAddr)) begin
            doneCount <= '0;
        end else if (cdb.valid) begin
            doneCount <= doneCount + 32'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst || (apbWrite && paddr == TakenAddr)) begin
            takenCount <= '0;
        end else if (cdb.valid && cdb.jumpTaken) begin
            takenCount <= takenCount + 32'd1;
        end
    end

    always_comb begin
        case (paddr)
            CtrlAddr:  prdata = {30'd0, flushReg, runReg};
            DoneAddr:  prdata = doneCount;
            TakenAddr: prdata = takenCount;
            default:   prdata = '0;
        endcase
    end

    assign ctrl = '{run: runReg, flush: flushReg};

endmodule

`default_nettype wire

//--- rtl/exeCore.sv
`timescale 1ns/1ps
`default_nettype none

module exeCore #(
    parameter int RsDepth = 4
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               dispatchValid,
    input  exePkg::dispatchReq dispatch,
    output logic               dispatchReady,
    input  exePkg::cdbResult   extCdb,
    output exePkg::cdbResult   cdb,
    input  logic [3:0]         paddr,
    input  logic               psel,
    input  logic               penable,
    input  logic               pwrite,
    input  logic [31:0]        pwdata,
    output logic [31:0]        prdata,
    output logic               pready
);

    exePkg::ctrlState ctrl;
    logic             issueValid;
    exePkg::issueReq  issue;

    exeCtrlRegs ctrlRegs (
        .clk     (clk),
        .rst     (rst),
        .paddr   (paddr),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .cdb     (cdb),
        .ctrl    (ctrl)
    );

    reservationStation #(
        .RsDepth (RsDepth)
    ) station (
        .clk           (clk),
        .rst           (rst),
        .ctrl          (ctrl),
        .dispatchValid (dispatchValid),
        .dispatch      (dispatch),
        .dispatchReady (dispatchReady),
        .cdb           (cdb),
        .extCdb        (extCdb),
        .issueValid    (issueValid),
        .issue         (issue)
    );

    // The common data bus goes back to the station and out to the reorder buffer
    intExecute execute (
        .clk        (clk),
        .rst        (rst),
        .run        (ctrl.run),
        .issueValid (issueValid),
        .issue      (issue),
        .cdb        (cdb)
    );

endmodule

`default_nettype wire

//--- sim/exeCoreTb.sv
`timescale 1ns/1ps
`default_nettype none

module exeCoreTb;

    localparam int RsDepth   = 4;
    localparam int NickCount = 1 << exePkg::NickWidth;
    localparam int BurstOps  = 12;

    // Dispatches and register accesses issued outside the data file
    localparam int InlineTests = 40;

    logic               clk;
    logic               rst;
    logic               dispatchValid;
    exePkg::dispatchReq dispatch;
    logic               dispatchReady;
    exePkg::cdbResult   extCdb;
    exePkg::cdbResult   cdb;
    logic [3:0]         paddr;
    logic               psel;
    logic               penable;
    logic               pwrite;
    logic [31:0]        pwdata;
    logic [31:0]        prdata;
    logic               pready;

    logic             pending [NickCount];
    exePkg::cdbResult expected [NickCount];
    int               pendingCount = 0;
    int               resultsSeen = 0;
    int               takenSeen = 0;
    int               cycleCount = 0;
    int               cycleLimit = 100 + 20 * InlineTests;
    logic [31:0]      rngState = 32'h52c3_3d15;

    exeCore #(
        .RsDepth (RsDepth)
    ) UUT (
        .clk           (clk),
        .rst           (rst),
        .dispatchValid (dispatchValid),
        .dispatch      (dispatch),
        .dispatchReady (dispatchReady),
        .extCdb        (extCdb),
        .cdb           (cdb),
        .paddr         (paddr),
        .psel          (psel),
        .penable       (penable),
        .pwrite        (pwrite),
        .pwdata        (pwdata),
        .prdata        (prdata),
        .pready        (pready)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic abortRun(input string why);
        $display("%s", why);
        $display("Simulation failed");
        $fatal(1, "Run stopped at first error");
    endtask

    task automatic compareResult(input exePkg::cdbResult got, input exePkg::cdbResult exp);
        if (got !== exp) begin
            abortRun($sformatf("Fail cdb nick %h: data %h taken %h target %h, expected %h %h %h",
                got.nick, got.data, got.jumpTaken, got.jumpTarget,
                exp.data, exp.jumpTaken, exp.jumpTarget));
        end
    endtask

    task automatic compareWord(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            abortRun($sformatf("Fail %s: got %h expected %h", name, got, exp));
        end
    endtask

    task automatic compareBit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            abortRun($sformatf("Fail %s: got %h expected %h", name, got, exp));
        end
    endtask

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic exePkg::dispatchReq makeReq(
        input exePkg::exeOp op, input logic [31:0] pc, input logic [31:0] imm,
        input logic [3:0] rd, input logic v1, input logic [3:0] n1, input logic [31:0] val1,
        input logic v2, input logic [3:0] n2, input logic [31:0] val2
    );
        exePkg::dispatchReq r;
        r.op     = op;
        r.pc     = pc;
        r.imm    = imm;
        r.rdNick = rd;
        r.src1   = '{v1, n1, val1};
        r.src2   = '{v2, n2, val2};
        return r;
    endfunction

    function automatic exePkg::cdbResult makeExp(
        input logic [3:0] nick, input logic [31:0] data, input logic taken, input logic [31:0] target
    );
        return '{1'b1, nick, data, taken, target};
    endfunction

    // Expected outcome of one operation for the random burst
    function automatic exePkg::cdbResult referenceResult(input exePkg::issueReq q);
        exePkg::cdbResult r;
        logic [31:0]      a;
        logic [31:0]      b;
        logic             cond;
        a      = q.rs1Value;
        b      = q.rs2Value;
        r      = makeExp(q.rdNick, 32'd0, 1'b0, 32'd0);
        case (q.op)
            exePkg::OpLui:   r.data = q.imm;
            exePkg::OpAuipc: r.data = q.pc + q.imm;
            exePkg::OpJal:   r.data = q.pc + 32'd4;
            exePkg::OpJalr:  r.data = q.pc + 32'd4;
            exePkg::OpAddi:  r.data = a + q.imm;
            exePkg::OpSlti:  r.data = ($signed(a) < $signed(q.imm)) ? 32'd1 : 32'd0;
            exePkg::OpSltiu: r.data = (a < q.imm) ? 32'd1 : 32'd0;
            exePkg::OpXori:  r.data = a ^ q.imm;
            exePkg::OpOri:   r.data = a | q.imm;
            exePkg::OpAndi:  r.data = a & q.imm;
            exePkg::OpSlli:  r.data = a << q.imm[4:0];
            exePkg::OpSrli:  r.data = a >> q.imm[4:0];
            exePkg::OpSrai:  r.data = $signed(a) >>> q.imm[4:0];
            exePkg::OpAdd:   r.data = a + b;
            exePkg::OpSub:   r.data = a - b;
            exePkg::OpSll:   r.data = a << b[4:0];
            exePkg::OpSlt:   r.data = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            exePkg::OpSltu:  r.data = (a < b) ? 32'd1 : 32'd0;
            exePkg::OpXor:   r.data = a ^ b;
            exePkg::OpSrl:   r.data = a >> b[4:0];
            exePkg::OpSra:   r.data = $signed(a) >>> b[4:0];
            exePkg::OpOr:    r.data = a | b;
            exePkg::OpAnd:   r.data = a & b;
            default:         r.data = 32'd0;
        endcase
        case (q.op)
            exePkg::OpBeq:  cond = a == b;
            exePkg::OpBne:  cond = a != b;
            exePkg::OpBlt:  cond = $signed(a) < $signed(b);
            exePkg::OpBge:  cond = $signed(a) >= $signed(b);
            exePkg::OpBltu: cond = a < b;
            exePkg::OpBgeu: cond = a >= b;
            default:        cond = 1'b0;
        endcase
        if (q.op inside {exePkg::OpBeq, exePkg::OpBne, exePkg::OpBlt,
                         exePkg::OpBge, exePkg::OpBltu, exePkg::OpBgeu}) begin
            r.jumpTaken  = cond;
            r.jumpTarget = cond ? q.pc + q.imm : q.pc + 32'd4;
        end else if (q.op == exePkg::OpJal) begin
            r.jumpTaken  = 1'b1;
            r.jumpTarget = q.pc + q.imm;
        end else if (q.op == exePkg::OpJalr) begin
            r.jumpTaken  = 1'b1;
            r.jumpTarget = (a + q.imm) & ~32'd1;
        end
        return r;
    endfunction

    // A nick is reused only after its earlier result has been checked
    task automatic dispatchOp(
        input exePkg::dispatchReq req, input exePkg::cdbResult exp, input logic expectResult
    );
        while (pending[req.rdNick]) @(posedge clk);
        if (expectResult) begin
            pending[req.rdNick]  = 1'b1;
            expected[req.rdNick] = exp;
            pendingCount++;
        end
        @(posedge clk);
        dispatch      <= req;
        dispatchValid <= 1'b1;
        do @(posedge clk); while (!dispatchReady);
        dispatchValid <= 1'b0;
    endtask

    task automatic broadcastExt(input logic [3:0] nick, input logic [31:0] data);
        @(posedge clk);
        extCdb <= '{1'b1, nick, data, 1'b0, 32'd0};
        @(posedge clk);
        extCdb <= '0;
    endtask

    task automatic writeRegister(input logic [3:0] addr, input logic [31:0] data);
        @(posedge clk);
        paddr   <= addr;
        pwdata  <= data;
        pwrite  <= 1'b1;
        psel    <= 1'b1;
        penable <= 1'b0;
        @(posedge clk);
        penable <= 1'b1;
        @(posedge clk);
        compareBit("pready", pready, 1'b1);
        psel    <= 1'b0;
        penable <= 1'b0;
        pwrite  <= 1'b0;
    endtask

    task automatic readRegister(input logic [3:0] addr, output logic [31:0] data);
        @(posedge clk);
        paddr   <= addr;
        pwrite  <= 1'b0;
        psel    <= 1'b1;
        penable <= 1'b0;
        @(posedge clk);
        penable <= 1'b1;
        @(posedge clk);
        compareBit("pready", pready, 1'b1);
        data = prdata;
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic waitIdle();
        while (pendingCount != 0) @(posedge clk);
    endtask

    task automatic runFileTests();
        int                 fd;
        int                 n;
        logic [63:0]        tag;
        logic [8*256-1:0]   line;
        logic [31:0]        f [13];
        exePkg::dispatchReq req;
        fd = $fopen("sim/exeTests.txt", "r");
        if (fd == 0) begin
            abortRun("Could not open the test data file sim/exeTests.txt");
        end else begin
            while (!$feof(fd)) begin
                n = $fscanf(fd, "%s", tag);
                if (n == 1 && tag == "#") begin
                    n = $fgets(line, fd);
                end else if (n == 1 && tag == "D") begin
                    n = $fscanf(fd, "%h %h %h %h %h %h %h %h %h %h %h %h %h",
                        f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9],
                        f[10], f[11], f[12]);
                    cycleLimit += 20;
                    req = makeReq(exePkg::exeOp'(f[0][4:0]), f[1], f[2], f[3][3:0],
                        f[4][0], f[5][3:0], f[6], f[7][0], f[8][3:0], f[9]);
                    dispatchOp(req, makeExp(f[3][3:0], f[10], f[11][0], f[12]), 1'b1);
                end else if (n == 1 && tag == "X") begin
                    n = $fscanf(fd, "%h %h", f[0], f[1]);
                    cycleLimit += 20;
                    broadcastExt(f[0][3:0], f[1]);
                end else if (n == 1) begin
                    abortRun("The test data file holds a line of unknown kind");
                end
            end
            $fclose(fd);
        end
    endtask

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount > cycleLimit) begin
            abortRun($sformatf("Timeout after %0d cycles with results still missing", cycleCount));
        end
    end

    // Every result must match the open dispatch of its nick
    always @(posedge clk) begin
        if (!rst && cdb.valid === 1'b1) begin
            if (!pending[cdb.nick]) begin
                abortRun($sformatf("A result with nick %h appeared that was not expected",
                    cdb.nick));
            end else begin
                compareResult(cdb, expected[cdb.nick]);
                pending[cdb.nick] = 1'b0;
                pendingCount--;
                resultsSeen++;
                if (cdb.jumpTaken) takenSeen++;
            end
        end
    end

    initial begin
        logic [31:0]     word;
        int              seenBefore;
        exePkg::issueReq q;

        rst           = 1'b1;
        dispatchValid = 1'b0;
        dispatch      = '0;
        extCdb        = '0;
        paddr         = '0;
        psel          = 1'b0;
        penable       = 1'b0;
        pwrite        = 1'b0;
        pwdata        = '0;
        for (int i = 0; i < NickCount; i++) begin
            pending[i] = 1'b0;
        end
        repeat (5) @(posedge clk);
        rst <= 1'b0;

        // Nothing may be accepted before run is set
        dispatch      <= makeReq(exePkg::OpAdd, 0, 0, 4'h1, 1, 0, 32'd1, 1, 0, 32'd2);
        dispatchValid <= 1'b1;
        repeat (4) begin
            @(posedge clk);
            if (dispatchReady) abortRun("dispatchReady went high while run was still clear");
        end
        dispatchValid <= 1'b0;
        readRegister(4'h0, word);
        compareWord("prdata CTRL", word, 32'd0);
        writeRegister(4'h0, 32'd1);

        runFileTests();
        waitIdle();

        // Four waiting entries fill the station and hold off a fifth
        for (int i = 0; i < 4; i++) begin
            dispatchOp(makeReq(exePkg::OpAddi, 0, 32'(i + 1), 4'(i + 1), 0, 4'he, 0, 1, 0, 0),
                makeExp(4'(i + 1), 32'h700 + 32'(i + 1), 1'b0, 32'd0), 1'b1);
        end
        repeat (3) begin
            @(posedge clk);
            if (dispatchReady) abortRun("dispatchReady stayed high with every slot busy");
        end
        fork
            dispatchOp(makeReq(exePkg::OpAdd, 0, 0, 4'h5, 1, 0, 32'd3, 1, 0, 32'd4),
                makeExp(4'h5, 32'd7, 1'b0, 32'd0), 1'b1);
            broadcastExt(4'he, 32'h700);
        join
        waitIdle();

        // Results hold off while run is clear and resume after
        dispatchOp(makeReq(exePkg::OpAddi, 0, 32'd1, 4'h6, 0, 4'hd, 0, 1, 0, 0),
            makeExp(4'h6, 32'h801, 1'b0, 32'd0), 1'b1);
        dispatchOp(makeReq(exePkg::OpSub, 0, 0, 4'h7, 0, 4'hd, 0, 1, 0, 32'd1),
            makeExp(4'h7, 32'h7ff, 1'b0, 32'd0), 1'b1);
        writeRegister(4'h0, 32'd0);
        broadcastExt(4'hd, 32'h800);
        seenBefore = resultsSeen;
        repeat (10) @(posedge clk);
        compareWord("cdb.valid count while stopped", 32'(resultsSeen), 32'(seenBefore));
        writeRegister(4'h0, 32'd1);
        waitIdle();

        // Flushed entries must never broadcast
        dispatchOp(makeReq(exePkg::OpAdd, 0, 0, 4'h8, 0, 4'hc, 0, 0, 4'hc, 0), '0, 1'b0);
        dispatchOp(makeReq(exePkg::OpXor, 0, 0, 4'h9, 0, 4'hc, 0, 1, 0, 32'd5), '0, 1'b0);
        writeRegister(4'h0, 32'd3);
        broadcastExt(4'hc, 32'h55);
        repeat (10) @(posedge clk);
        if (!dispatchReady) abortRun("The station still held entries after a flush");

        for (int i = 0; i < BurstOps; i++) begin
            rngState = xorshift(rngState);
            q.op     = exePkg::exeOp'(5'(rngState % 32'd29));
            rngState = xorshift(rngState);
            q.rs1Value = rngState;
            rngState = xorshift(rngState);
            q.rs2Value = (i % 3 == 0) ? q.rs1Value : rngState;
            rngState = xorshift(rngState);
            q.imm    = {{20{rngState[11]}}, rngState[11:0]};
            q.pc     = {16'd0, rngState[27:14], 2'b00};
            q.rdNick = 4'((i % 11) + 1);
            dispatchOp(makeReq(q.op, q.pc, q.imm, q.rdNick, 1, 0, q.rs1Value, 1, 0, q.rs2Value),
                referenceResult(q), 1'b1);
        end
        waitIdle();

        readRegister(4'h4, word);
        compareWord("prdata DONE", word, 32'(resultsSeen));
        readRegister(4'h8, word);
        compareWord("prdata TAKEN", word, 32'(takenSeen));
        writeRegister(4'h4, 32'd0);
        writeRegister(4'h8, 32'd0);
        readRegister(4'h4, word);
        compareWord("prdata DONE after clear", word, 32'd0);
        readRegister(4'h8, word);
        compareWord("prdata TAKEN after clear", word, 32'd0);

        $display("Simulation completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

//--- build.f
rtl/exePkg.sv
rtl/reservationStation.sv
rtl/intExecute.sv
rtl/exeCtrlRegs.sv
rtl/exeCore.sv
sim/exeCoreTb.sv

//--- Makefile
# Verilator flow for the integer execution core

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f build.f --top-module exeCoreTb

# The run passes only when the pass message shows up in the output
sim:
	verilator --binary --timing -f build.f --top-module exeCoreTb -o exeCoreSim
	@out="$$(./obj_dir/exeCoreSim 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation completed successfully"

clean:
	rm -rf obj_dir

//--- sim/exeTests.txt
# D op pc imm rd src1(valid nick value) src2(valid nick value) expData expTaken expTarget
# X nick data is a broadcast on the external bus, all fields in hex
D 13 0 0 1 1 0 fffffff0 1 0 24 14 0 0
D 14 0 0 2 1 0 fffffff0 1 0 24 ffffffcc 0 0
D 15 0 0 3 1 0 fffffff0 1 0 24 ffffff00 0 0
D 16 0 0 4 1 0 fffffff0 1 0 24 1 0 0
D 17 0 0 5 1 0 fffffff0 1 0 24 0 0 0
D 18 0 0 6 1 0 fffffff0 1 0 24 ffffffd4 0 0
D 19 0 0 7 1 0 fffffff0 1 0 24 0fffffff 0 0
D 1a 0 0 8 1 0 fffffff0 1 0 24 ffffffff 0 0
D 1b 0 0 9 1 0 fffffff0 1 0 24 fffffff4 0 0
D 1c 0 0 a 1 0 fffffff0 1 0 24 20 0 0
D a 0 fffff803 b 1 0 1234 1 0 0 a37 0 0
D b 0 fffff803 1 1 0 1234 1 0 0 0 0 0
D c 0 fffff803 2 1 0 1234 1 0 0 1 0 0
D d 0 fffff803 3 1 0 1234 1 0 0 ffffea37 0 0
D e 0 fffff803 4 1 0 1234 1 0 0 fffffa37 0 0
D f 0 fffff803 5 1 0 1234 1 0 0 1000 0 0
D 10 0 fffff803 6 1 0 1234 1 0 0 91a0 0 0
D 11 0 fffff803 7 1 0 1234 1 0 0 246 0 0
D 12 0 404 8 1 0 80000000 1 0 0 f8000000 0 0
D 0 0 abcde000 9 1 0 0 1 0 0 abcde000 0 0
D 1 100 2000 a 1 0 0 1 0 0 2100 0 0
# Branches, taken then not taken
D 4 200 40 b 1 0 5 1 0 5 0 1 240
D 4 200 40 1 1 0 5 1 0 6 0 0 204
D 5 200 40 2 1 0 5 1 0 6 0 1 240
D 5 200 40 3 1 0 5 1 0 5 0 0 204
D 6 200 40 4 1 0 ffffffff 1 0 1 0 1 240
D 6 200 40 5 1 0 1 1 0 ffffffff 0 0 204
D 7 200 40 6 1 0 1 1 0 ffffffff 0 1 240
D 7 200 40 7 1 0 ffffffff 1 0 1 0 0 204
D 8 200 40 8 1 0 1 1 0 ffffffff 0 1 240
D 8 200 40 9 1 0 ffffffff 1 0 1 0 0 204
D 9 200 40 a 1 0 ffffffff 1 0 1 0 1 240
D 9 200 40 b 1 0 1 1 0 ffffffff 0 0 204
D 2 300 ffffff00 1 1 0 0 1 0 0 304 1 200
D 3 400 10 2 1 0 1001 1 0 0 404 1 1010
# Chain waiting on external nicks f and e
D 13 0 0 3 0 f 0 1 0 5 105 0 0
D 14 0 0 4 0 3 0 0 e 0 100 0 0
D 18 0 0 5 1 0 ff 0 4 0 1ff 0 0
D a 0 10 6 0 e 0 1 0 0 15 0 0
X f 100
X e 5
# JALR link forwarded into an add
D 3 500 8 7 0 d 0 1 0 0 504 1 2008
D 13 0 0 8 0 7 0 0 d 0 2504 0 0
X d 2000
